/* sim.f */
cas_pkg.sv
cas_buffer.sv
cas_loader.sv
cas_player.sv
cas_fsk_modulator.sv
cas_tape_top.sv
tb_cas_tape.sv

/* Makefile */
# Verilator flow for the cassette path; run "make sim" or override any variable below

VERILATOR ?= verilator
TOP       ?= tb_cas_tape
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb_cas_tape.sv */
// Runs with half_period 4 and addr_width 8; the decoder follows one stream and stops at the first error
`timescale 1ns/1ps
`default_nettype none

module tb_cas_tape;

	localparam int hp = 4;
	localparam int aw = 8;
	// Cassette format as the model sees it
	localparam int lead_len = 16;
	localparam int stop_len = 2;
	// No edge for this long means the stream went quiet
	localparam int idle_limit = 2 * hp + 2;

	logic CLK_VIDEO;
	logic ioctl_isROMB;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [aw-1:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic ioctl_wait;
	logic motor;
	logic rewind;
	logic tape_select;
	logic tape_adc;
	logic cas_out;
	logic cas_audio_in;
	logic tape_end;

	int unsigned rng_state = 52833;
	logic [7:0] image [0:255];
	// Expected and decoded bit streams
	logic exp_bits[$];
	logic got[$];
	// Decoder state
	logic prev_out = 1'b0;
	logic fresh = 1'b1;
	int since_edge = 0;
	int quarters = 0;
	int halves = 0;
	int edge_count = 0;

	cas_tape_top #(.addr_width(aw), .half_period(hp)) cas_tape_top_inst (
		.CLK_VIDEO(CLK_VIDEO), .ioctl_isROMB(ioctl_isROMB),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_wait(ioctl_wait), .motor(motor), .rewind(rewind),
		.tape_select(tape_select), .tape_adc(tape_adc),
		.cas_out(cas_out), .cas_audio_in(cas_audio_in), .tape_end(tape_end)
	);

	always #20 CLK_VIDEO = ~CLK_VIDEO;

	//////////////////////////////////////////////////////////////////////
	// Error reporting and random numbers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_mismatch(input string what);
		$display("MISMATCH at %0t ns: %s", $time, what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out at %0t ns while %s", $time, what);
		$display("Something failed");
		$fatal(1);
	endtask

	// Plain LCG, upper bits are the better ones
	function automatic int next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return int'(rng_state[30:16]);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Host side and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic fill_image(input int count);
		for (int i = 0; i < count; i++) begin
			image[i] = 8'(next_random());
		end
	endtask

	// Leader of ones, then start bit, data LSB first and stop bits per byte
	task automatic build_expected(input int count);
		exp_bits.delete();
		repeat (lead_len) exp_bits.push_back(1'b1);
		for (int i = 0; i < count; i++) begin
			exp_bits.push_back(1'b0);
			for (int b = 0; b < 8; b++) begin
				exp_bits.push_back(image[i][b]);
			end
			repeat (stop_len) exp_bits.push_back(1'b1);
		end
	endtask

	// One-cycle writes, each only after ioctl_wait was seen low
	task automatic download_image(input logic [7:0] index, input int count,
			input logic expect_wait);
		int guard;
		int gap;
		ioctl_index = index;
		ioctl_download = 1'b1;
		@(posedge CLK_VIDEO);
		#1;
		for (int i = 0; i < count; i++) begin
			guard = 0;
			while (ioctl_wait) begin
				guard++;
				if (guard > 20) stop_on_timeout("waiting for ioctl_wait to fall");
				@(posedge CLK_VIDEO);
				#1;
			end
			ioctl_addr = aw'(i);
			ioctl_dout = image[i];
			ioctl_wr = 1'b1;
			@(posedge CLK_VIDEO);
			#1;
			ioctl_wr = 1'b0;
			// Buffer goes busy right after a tape write
			assert (ioctl_wait === expect_wait)
				else stop_on_mismatch($sformatf("ioctl_wait is %b after write %0d", ioctl_wait, i));
			gap = next_random() % 4;
			repeat (gap) begin
				@(posedge CLK_VIDEO);
				#1;
			end
		end
		ioctl_download = 1'b0;
		@(posedge CLK_VIDEO);
		#1;
	endtask

	task automatic wait_bits(input int count);
		int guard;
		guard = 0;
		while (got.size() < count) begin
			guard++;
			if (guard > 8 * hp * count + 200) stop_on_timeout("waiting for decoded bits");
			@(posedge CLK_VIDEO);
			#1;
		end
	endtask

	task automatic compare_bits(input int base, input int count);
		for (int i = 0; i < count; i++) begin
			assert (got[base + i] === exp_bits[i])
				else stop_on_mismatch($sformatf("bit %0d is %b, expected %b",
					i, got[base + i], exp_bits[i]));
		end
	endtask

	task automatic expect_no_toggle(input int cycles, input string what);
		int start;
		start = edge_count;
		repeat (cycles) @(posedge CLK_VIDEO);
		#1;
		assert (edge_count == start) else stop_on_mismatch(what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// FSK decoder
	//////////////////////////////////////////////////////////////////////

	// One half_period is a quarter of a 1, two are half of a 0
	task automatic decode_interval(input int len);
		if (quarters == 3) begin
			// Last quarter may stretch when the stream paused
			assert (len >= hp) else stop_on_mismatch($sformatf("short last quarter %0d", len));
			got.push_back(1'b1);
			quarters = 0;
		end else if (halves == 1) begin
			assert (len >= 2 * hp) else stop_on_mismatch($sformatf("short last half %0d", len));
			got.push_back(1'b0);
			halves = 0;
		end else if (quarters > 0) begin
			assert (len == hp) else stop_on_mismatch($sformatf("bad quarter %0d", len));
			quarters++;
		end else if (len == hp) begin
			quarters = 1;
		end else begin
			assert (len == 2 * hp) else stop_on_mismatch($sformatf("bad interval %0d", len));
			halves = 1;
		end
	endtask

	always @(posedge CLK_VIDEO) begin
		if (ioctl_isROMB) begin
			prev_out = 1'b0;
			fresh = 1'b1;
			since_edge = 0;
			quarters = 0;
			halves = 0;
			edge_count = 0;
		end else if (cas_out !== prev_out) begin
			edge_count++;
			// First edge after quiet only opens a bit
			if (!fresh) decode_interval(since_edge);
			fresh = 1'b0;
			since_edge = 1;
			prev_out = cas_out;
		end else begin
			if (since_edge < idle_limit) since_edge++;
			if (!fresh && since_edge == idle_limit) begin
				// Final half of the last bit has no closing edge
				if (quarters == 3) begin
					got.push_back(1'b1);
				end else if (halves == 1) begin
					got.push_back(1'b0);
				end else begin
					assert (quarters == 0 && halves == 0)
						else stop_on_mismatch("cas_out went quiet inside a bit");
				end
				quarters = 0;
				halves = 0;
				fresh = 1'b1;
			end
		end
	end

	// Cassette input selection, checked mid-cycle
	always @(negedge CLK_VIDEO) begin
		if (!ioctl_isROMB) begin
			if (tape_select) begin
				assert (cas_audio_in === tape_adc)
					else stop_on_mismatch("cas_audio_in does not follow tape_adc");
			end else begin
				assert (cas_audio_in === cas_out)
					else stop_on_mismatch("cas_audio_in differs from cas_out");
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int junk_len;
		int tape_len;
		int stop_at;
		int replay_base;
		CLK_VIDEO = 1'b0;
		ioctl_isROMB = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'h00;
		motor = 1'b0;
		rewind = 1'b0;
		tape_select = 1'b0;
		tape_adc = 1'b0;
		repeat (2) @(posedge CLK_VIDEO);
		#1;
		ioctl_isROMB = 1'b0;
		@(posedge CLK_VIDEO);
		#1;

		// Non-tape index, motor on, nothing may play
		junk_len = 4 + next_random() % 16;
		fill_image(junk_len);
		motor = 1'b1;
		download_image(8'h07, junk_len, 1'b0);
		expect_no_toggle(20 * hp, "cas_out toggled after a non-tape download");
		assert (tape_end === 1'b1) else stop_on_mismatch("tape_end low with an empty tape");
		motor = 1'b0;

		// Tape image, upper index bits set on purpose
		tape_len = 4 + next_random() % 16;
		fill_image(tape_len);
		build_expected(tape_len);
		download_image(8'hC4, tape_len, 1'b1);
		assert (tape_end === 1'b0) else stop_on_mismatch("tape_end high with a loaded tape");
		motor = 1'b1;

		// Motor off partway, then resume
		stop_at = 20 + next_random() % (exp_bits.size() - 30);
		wait_bits(stop_at);
		motor = 1'b0;
		repeat (4 * hp + 2) @(posedge CLK_VIDEO);
		#1;
		expect_no_toggle(12 * hp, "cas_out kept toggling with motor off");
		motor = 1'b1;
		wait_bits(exp_bits.size());
		repeat (4 * hp) @(posedge CLK_VIDEO);
		#1;
		assert (got.size() == exp_bits.size())
			else stop_on_mismatch($sformatf("%0d bits decoded, expected %0d",
				got.size(), exp_bits.size()));
		compare_bits(0, exp_bits.size());
		assert (tape_end === 1'b1) else stop_on_mismatch("tape_end low after the last byte");
		expect_no_toggle(12 * hp, "cas_out toggled after the end of tape");

		// Rewind restarts with the leader and byte zero
		replay_base = got.size();
		rewind = 1'b1;
		@(posedge CLK_VIDEO);
		#1;
		rewind = 1'b0;
		wait_bits(replay_base + lead_len + 1 + 8 + stop_len);
		compare_bits(replay_base, lead_len + 1 + 8 + stop_len);

		// ADC path while the tape keeps playing
		tape_select = 1'b1;
		repeat (40) begin
			tape_adc = (next_random() % 2) == 1;
			@(posedge CLK_VIDEO);
			#1;
		end
		tape_select = 1'b0;
		tape_adc = 1'b0;
		repeat (40) @(posedge CLK_VIDEO);
		#1;
		motor = 1'b0;

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* cas_tape_top.sv */
// Cassette path only; the ADC arrives as a single bit and the buffer is internal
`timescale 1ns/1ps
`default_nettype none

module cas_tape_top #(
	parameter int addr_width = 12,
	parameter int half_period = 8949
) (
	input  wire                    CLK_VIDEO,
	input  wire                    ioctl_isROMB,
	input  wire                    ioctl_download,
	input  wire [7:0]              ioctl_index,
	input  wire                    ioctl_wr,
	input  wire [addr_width-1:0]   ioctl_addr,
	input  wire [7:0]              ioctl_dout,
	output logic                   ioctl_wait,
	input  wire                    motor,
	input  wire                    rewind,
	input  wire                    tape_select,
	input  wire                    tape_adc,
	output logic                   cas_out,
	output logic                   cas_audio_in,
	output logic                   tape_end
);

	//////////////////////////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////////////////////////

	// Buffer write side
	logic wr_en;
	logic [addr_width-1:0] wr_addr;
	logic [7:0] wr_data;
	// Buffer read side
	logic rd_en;
	logic [addr_width-1:0] rd_addr;
	logic [7:0] rd_data;
	logic ready;
	// Download status
	logic tape_loading;
	logic [addr_width:0] image_length;
	logic load_done;
	// Bit stream
	logic bit_value;
	logic bit_valid;
	logic bit_taken;

	cas_loader #(.addr_width(addr_width)) loader (
		.CLK_VIDEO(CLK_VIDEO), .ioctl_isROMB(ioctl_isROMB),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_wait(ioctl_wait), .ready(ready),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.tape_loading(tape_loading), .image_length(image_length), .load_done(load_done)
	);

	cas_buffer #(.addr_width(addr_width)) buffer (
		.CLK_VIDEO(CLK_VIDEO), .ioctl_isROMB(ioctl_isROMB),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .ready(ready)
	);

	cas_player #(.addr_width(addr_width)) player (
		.CLK_VIDEO(CLK_VIDEO), .ioctl_isROMB(ioctl_isROMB),
		.motor(motor), .rewind(rewind), .tape_loading(tape_loading),
		.image_length(image_length), .load_done(load_done), .ready(ready),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.bit_value(bit_value), .bit_valid(bit_valid), .bit_taken(bit_taken),
		.tape_end(tape_end)
	);

	cas_fsk_modulator #(.half_period(half_period)) modulator (
		.CLK_VIDEO(CLK_VIDEO), .ioctl_isROMB(ioctl_isROMB),
		.bit_value(bit_value), .bit_valid(bit_valid), .bit_taken(bit_taken),
		.tape_select(tape_select), .tape_adc(tape_adc),
		.cas_out(cas_out), .cas_audio_in(cas_audio_in)
	);

endmodule

`default_nettype wire

/* cas_fsk_modulator.sv */
// Each bit lasts four half_period intervals; half_period must be at least 1
`timescale 1ns/1ps
`default_nettype none

module cas_fsk_modulator #(
	parameter int half_period = 8949
) (
	input  wire   CLK_VIDEO,
	input  wire   ioctl_isROMB,
	input  wire   bit_value,
	input  wire   bit_valid,
	output logic  bit_taken,
	input  wire   tape_select,
	input  wire   tape_adc,
	output logic  cas_out,
	output logic  cas_audio_in
);

	localparam int cnt_width = $clog2(half_period + 1);

	// Cycles inside one high-tone half
	logic [cnt_width-1:0] period_cnt;
	// Which of the four halves of the bit is playing
	logic [1:0] half_cnt;
	logic playing;
	// Bit being played
	logic cur_bit;
	logic half_end;
	logic bit_end;

	assign half_end = (period_cnt == cnt_width'(half_period - 1));
	// Idle counts as a boundary so a new bit starts at once
	assign bit_end = !playing || (half_end && (half_cnt == 2'd3));
	assign bit_taken = bit_end && bit_valid;

	// Cassette input selection
	assign cas_audio_in = tape_select ? tape_adc : cas_out;

	//////////////////////////////////////////////////////////////////////
	// Tone generator
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or posedge ioctl_isROMB) begin
		if (ioctl_isROMB) begin
			period_cnt <= '0;
			half_cnt <= 2'd0;
			playing <= 1'b0;
			cur_bit <= 1'b0;
			cas_out <= 1'b0;
		end else if (bit_end) begin
			if (bit_valid) begin
				// Start of a bit always flips the line
				cur_bit <= bit_value;
				cas_out <= !cas_out;
				period_cnt <= '0;
				half_cnt <= 2'd0;
				playing <= 1'b1;
			end else begin
				// Starved, hold the level
				playing <= 1'b0;
			end
		end else if (half_end) begin
			period_cnt <= '0;
			half_cnt <= half_cnt + 2'd1;
			// High tone flips every half, low tone only at the middle
			if (cur_bit || (half_cnt == 2'd1)) begin
				cas_out <= !cas_out;
			end
		end else begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* cas_player.sv */
// Plays bytes 0 to image_length-1 once per rewind; no reads are issued during a tape download
`timescale 1ns/1ps
`default_nettype none

module cas_player import cas_pkg::*; #(
	parameter int addr_width = 12
) (
	input  wire                    CLK_VIDEO,
	input  wire                    ioctl_isROMB,
	input  wire                    motor,
	input  wire                    rewind,
	input  wire                    tape_loading,
	input  wire [addr_width:0]     image_length,
	input  wire                    load_done,
	input  wire                    ready,
	output logic                   rd_en,
	output logic [addr_width-1:0]  rd_addr,
	input  wire [7:0]              rd_data,
	output logic                   bit_value,
	output logic                   bit_valid,
	input  wire                    bit_taken,
	output logic                   tape_end
);

	// FSM phases
	localparam logic [1:0] st_leader = 2'd0;
	localparam logic [1:0] st_fetch  = 2'd1;
	localparam logic [1:0] st_frame  = 2'd2;
	localparam logic [1:0] st_end    = 2'd3;

	localparam int lead_width = $clog2(leader_bits + 1);
	localparam int pos_width = $clog2(frame_bits + 1);

	logic [1:0] state;
	logic [lead_width-1:0] leader_cnt;
	// Bit position inside the frame, 0 is the start bit
	logic [pos_width-1:0] frame_pos;
	logic [2:0] data_idx;
	// Byte now being framed, and next byte to request
	logic [addr_width:0] byte_cnt;
	logic [addr_width:0] fetch_cnt;
	// Prefetch stage
	logic fetch_busy;
	logic next_full;
	logic [7:0] next_byte;
	logic [7:0] cur_byte;
	logic at_end;
	logic restart;
	logic offer_ok;

	assign at_end = (byte_cnt >= image_length);
	assign restart = rewind || load_done;
	// Bits flow only with motor on, no download and tape left
	assign offer_ok = motor && !tape_loading && !restart && !at_end;

	//////////////////////////////////////////////////////////////////////
	// Prefetch request
	//////////////////////////////////////////////////////////////////////

	assign rd_addr = fetch_cnt[addr_width-1:0];
	assign rd_en = !fetch_busy && !next_full && (fetch_cnt < image_length) && ready
		&& !tape_loading && !restart;

	//////////////////////////////////////////////////////////////////////
	// Bit offered to the modulator
	//////////////////////////////////////////////////////////////////////

	// Data bits start at position 1, LSB first
	assign data_idx = frame_pos[2:0] - 3'd1;

	always_comb begin
		bit_value = 1'b1;
		bit_valid = 1'b0;
		case (state)
			st_leader: begin
				bit_valid = offer_ok;
			end
			st_frame: begin
				bit_valid = offer_ok;
				if (frame_pos == '0) begin
					bit_value = 1'b0;
				end else if (frame_pos < pos_width'(frame_bits - stop_bits)) begin
					bit_value = cur_byte[data_idx];
				end
			end
			default: begin
				// Nothing to send
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or posedge ioctl_isROMB) begin
		if (ioctl_isROMB) begin
			state <= st_leader;
			leader_cnt <= '0;
			frame_pos <= '0;
			byte_cnt <= '0;
			fetch_cnt <= '0;
			fetch_busy <= 1'b0;
			next_full <= 1'b0;
			tape_end <= 1'b0;
		end else begin
			tape_end <= at_end;
			if (restart) begin
				// Back to address zero, any read in flight is dropped
				state <= st_leader;
				leader_cnt <= '0;
				frame_pos <= '0;
				byte_cnt <= '0;
				fetch_cnt <= '0;
				fetch_busy <= 1'b0;
				next_full <= 1'b0;
			end else begin
				if (rd_en) begin
					fetch_busy <= 1'b1;
					fetch_cnt <= fetch_cnt + 1'b1;
				end else if (fetch_busy && ready) begin
					// Ready is back, read data is valid
					fetch_busy <= 1'b0;
					next_full <= 1'b1;
				end
				case (state)
					st_leader: begin
						if (bit_taken) begin
							leader_cnt <= leader_cnt + 1'b1;
							if (leader_cnt == lead_width'(leader_bits - 1)) begin
								state <= st_fetch;
							end
						end
					end
					st_fetch: begin
						// Wait for the prefetched byte
						if (at_end) begin
							state <= st_end;
						end else if (next_full) begin
							cur_byte <= next_byte;
							next_full <= 1'b0;
							frame_pos <= '0;
							state <= st_frame;
						end
					end
					st_frame: begin
						if (bit_taken) begin
							if (frame_pos == pos_width'(frame_bits - 1)) begin
								frame_pos <= '0;
								byte_cnt <= byte_cnt + 1'b1;
								state <= st_fetch;
							end else begin
								frame_pos <= frame_pos + 1'b1;
							end
						end
					end
					default: begin
						// Tape exhausted, only a rewind leaves here
					end
				endcase
			end
		end
	end

	// Prefetch payload
	always_ff @(posedge CLK_VIDEO) begin
		if (!restart && fetch_busy && ready) begin
			next_byte <= rd_data;
		end
	end

endmodule

`default_nettype wire

/* cas_loader.sv */
// Host must hold off ioctl_wr while ioctl_wait is high; addresses past addr_width bits wrap
`timescale 1ns/1ps
`default_nettype none

module cas_loader import cas_pkg::*; #(
	parameter int addr_width = 12
) (
	input  wire                    CLK_VIDEO,
	input  wire                    ioctl_isROMB,
	input  wire                    ioctl_download,
	input  wire [7:0]              ioctl_index,
	input  wire                    ioctl_wr,
	input  wire [addr_width-1:0]   ioctl_addr,
	input  wire [7:0]              ioctl_dout,
	output logic                   ioctl_wait,
	input  wire                    ready,
	output logic                   wr_en,
	output logic [addr_width-1:0]  wr_addr,
	output logic [7:0]             wr_data,
	output logic                   tape_loading,
	output logic [addr_width:0]    image_length,
	output logic                   load_done
);

	// Download of a CAS image in progress
	logic is_tape;
	// Same, one cycle late, for edge detection
	logic tape_q;
	// Length implied by the current write address
	logic [addr_width:0] next_length;

	assign is_tape = ioctl_download && (ioctl_index[5:0] == cas_index);
	assign tape_loading = is_tape;

	// Stall the host while the buffer digests the last byte
	assign ioctl_wait = is_tape && !ready;

	// Writes go straight to the buffer, dropped when it is busy
	assign wr_en = is_tape && ioctl_wr && ready;
	assign wr_addr = ioctl_addr;
	assign wr_data = ioctl_dout;

	assign next_length = {1'b0, ioctl_addr} + 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Length tracking and end of download
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or posedge ioctl_isROMB) begin
		if (ioctl_isROMB) begin
			tape_q <= 1'b0;
			load_done <= 1'b0;
			image_length <= '0;
		end else begin
			tape_q <= is_tape;
			// Falling edge of a tape download
			load_done <= tape_q && !is_tape;
			if (wr_en && (!tape_q || (next_length > image_length))) begin
				// Highest address so far, or first byte of a new image
				image_length <= next_length;
			end else if (is_tape && !tape_q) begin
				// New image starts empty
				image_length <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* cas_buffer.sv */
// Single-port busy model: one access per busy window, write wins over read in the same cycle
`timescale 1ns/1ps
`default_nettype none

module cas_buffer import cas_pkg::*; #(
	parameter int addr_width = 12
) (
	input  wire                    CLK_VIDEO,
	input  wire                    ioctl_isROMB,
	input  wire                    wr_en,
	input  wire [addr_width-1:0]   wr_addr,
	input  wire [7:0]              wr_data,
	input  wire                    rd_en,
	input  wire [addr_width-1:0]   rd_addr,
	output logic [7:0]             rd_data,
	output logic                   ready
);

	// Enough bits to hold the full latency value
	localparam int cnt_width = $clog2(buffer_latency + 1);

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Tape image, one byte per address
	logic [7:0] mem [0:(1 << addr_width) - 1];

	// Remaining busy cycles, zero means idle
	logic [cnt_width-1:0] busy_cnt;

	// Idle whenever the counter has run out
	assign ready = (busy_cnt == '0);

	//////////////////////////////////////////////////////////////////////
	// Busy counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or posedge ioctl_isROMB) begin
		if (ioctl_isROMB) begin
			busy_cnt <= '0;
		end else if ((wr_en || rd_en) && ready) begin
			// Accepted access, go busy from the next cycle on
			busy_cnt <= cnt_width'(buffer_latency);
		end else if (!ready) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory array
	//////////////////////////////////////////////////////////////////////

	// Read data is latched at the access and held until the next read
	always_ff @(posedge CLK_VIDEO) begin
		if (ready) begin
			if (wr_en) begin
				mem[wr_addr] <= wr_data;
			end else if (rd_en) begin
				rd_data <= mem[rd_addr];
			end
		end
	end

endmodule

`default_nettype wire

/* cas_pkg.sv */
// Shared tape constants; the cassette index lives in the low six bits of the ioctl index only
`default_nettype none

package cas_pkg;

	//////////////////////////////////////////////////////////////////////
	// Download decoding
	//////////////////////////////////////////////////////////////////////

	// ioctl index of a CAS image
	// Upper two index bits carry no meaning here
	localparam logic [5:0] cas_index = 6'd4;

	//////////////////////////////////////////////////////////////////////
	// Buffer memory
	//////////////////////////////////////////////////////////////////////

	// Cycles the buffer stays busy after it accepts an access
	localparam int buffer_latency = 3;

	//////////////////////////////////////////////////////////////////////
	// Cassette framing
	//////////////////////////////////////////////////////////////////////

	// Ones sent after each rewind, ahead of the first byte
	localparam int leader_bits = 16;

	// Trailing ones after every byte
	localparam int stop_bits = 2;

	// Start bit, eight data bits, then the stop bits
	localparam int frame_bits = 1 + 8 + stop_bits;

endpackage

`default_nettype wire
